/* vlog.f */
hdl/dcache_pkg.sv
hdl/dcache_if.sv
hdl/dcache_tag_array.sv
hdl/dcache_data_ram.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
verification/dcache_assert.sv
verification/tb_dcache.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - hdl/dcache_pkg.sv
  - hdl/dcache_if.sv
  - hdl/dcache_tag_array.sv
  - hdl/dcache_data_ram.sv
  - hdl/dcache_ctrl.sv
  - hdl/dcache_top.sv
  - target: simulation
    files:
      - verification/dcache_assert.sv
      - verification/tb_dcache.sv

/* verification/tb_dcache.sv */
/*
  random cpu traffic against a reference memory, one request at a time
  memory side answered by a word array with 0 to 3 cycle delays
  64 test words, 8 tags over 8 sets of 16, so evictions are frequent
  ar and aw are never driven together
*/
`timescale 1ns/1ns

module tb_dcache;

  typedef logic [dcache_pkg::ADDR_WIDTH-1:0] addr_t;
  typedef logic [dcache_pkg::DATA_WIDTH-1:0] word_t;
  typedef logic [dcache_pkg::STRB_WIDTH-1:0] strb_t;

  localparam int    NUM_OPS         = 600;
  localparam int    NUM_SLOTS       = 64;
  localparam int    CLK_PERIOD      = 100;
  localparam int    WATCHDOG_CYCLES = (NUM_OPS + NUM_SLOTS) * 40;
  localparam addr_t BASE_ADDR       = 32'h4000_0000;
  localparam addr_t SLOT_MASK       = 32'h0000_03b8;  // tag [9:7], index [5:3]

  logic  clk = 1'b0;
  logic  rst;
  logic  ar_valid_i, ar_ready_o, r_valid_o, r_ready_i;
  logic  aw_valid_i, aw_ready_o, w_valid_i, w_ready_o, b_valid_o, b_ready_i;
  logic  mem_ar_valid_o, mem_ar_ready_i, mem_r_valid_i, mem_r_ready_o;
  logic  mem_aw_valid_o, mem_aw_ready_i, mem_w_valid_o, mem_w_ready_i;
  logic  mem_b_valid_i, mem_b_ready_o;
  addr_t ar_addr_i, aw_addr_i, mem_ar_addr_o, mem_aw_addr_o;
  word_t r_data_o, w_data_i, mem_r_data_i, mem_w_data_o;
  strb_t w_strb_i, mem_w_strb_o;

  word_t  mem_model [NUM_SLOTS];  // backing memory
  word_t  ref_mem   [NUM_SLOTS];  // architectural contents
  integer seed = 23518;

  dcache_top #(.INDEX_WIDTH(4)) i_dcache_top (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic addr_t slot_addr(input int slot);
    return BASE_ADDR | ((slot / 8) << 7) | ((slot % 8) << 3);
  endfunction

  function automatic int addr_slot(input addr_t addr);
    if ((addr & ~SLOT_MASK) != BASE_ADDR) begin
      return -1;
    end
    return int'({addr[9:7], addr[5:3]});
  endfunction

  function automatic int random_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic word_t merge_bytes(input word_t old_word, input word_t new_word,
                                        input strb_t strb);
    word_t result;
    result = old_word;
    for (int b = 0; b < dcache_pkg::STRB_WIDTH; b++) begin
      if (strb[b]) result[8*b +: 8] = new_word[8*b +: 8];
    end
    return result;
  endfunction

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_equal(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      report_error($sformatf("Mismatch %s: expected 0x%h, actual 0x%h", name, expected, actual));
    end
  endtask

  task automatic check_requests_blocked();
    check_equal("ar_ready_o", 0, ar_ready_o);
    check_equal("aw_ready_o", 0, aw_ready_o);
  endtask

  task automatic check_reset_outputs();
    check_equal("ar_ready_o", 1, ar_ready_o);
    check_equal("aw_ready_o", 1, aw_ready_o);
    check_equal("r_valid_o", 0, r_valid_o);
    check_equal("w_ready_o", 0, w_ready_o);
    check_equal("b_valid_o", 0, b_valid_o);
    check_equal("mem_ar_valid_o", 0, mem_ar_valid_o);
    check_equal("mem_aw_valid_o", 0, mem_aw_valid_o);
    check_equal("mem_w_valid_o", 0, mem_w_valid_o);
    check_equal("mem_r_ready_o", 0, mem_r_ready_o);
    check_equal("mem_b_ready_o", 0, mem_b_ready_o);
  endtask

  // memory side, entered at the negedge where a valid is seen
  task automatic serve_mem_read();
    int slot;
    repeat (random_below(4)) @(negedge clk);
    mem_ar_ready_i = 1'b1;
    slot = addr_slot(mem_ar_addr_o);
    if (slot < 0) begin
      report_error($sformatf("memory read from 0x%h outside the test range", mem_ar_addr_o));
    end
    @(negedge clk);
    mem_ar_ready_i = 1'b0;
    repeat (random_below(4)) @(negedge clk);
    mem_r_valid_i = 1'b1;
    mem_r_data_i  = mem_model[slot];
    while (!mem_r_ready_o) @(negedge clk);
    @(negedge clk);
    mem_r_valid_i = 1'b0;
  endtask

  task automatic serve_mem_write();
    int slot;
    repeat (random_below(4)) @(negedge clk);
    mem_aw_ready_i = 1'b1;
    slot = addr_slot(mem_aw_addr_o);
    if (slot < 0) begin
      report_error($sformatf("writeback to 0x%h outside the test range", mem_aw_addr_o));
    end
    @(negedge clk);
    mem_aw_ready_i = 1'b0;
    while (!mem_w_valid_o) @(negedge clk);
    repeat (random_below(4)) @(negedge clk);
    mem_w_ready_i = 1'b1;
    check_equal("mem_w_strb_o", {dcache_pkg::STRB_WIDTH{1'b1}}, mem_w_strb_o);
    check_equal("mem_w_data_o", ref_mem[slot], mem_w_data_o);
    mem_model[slot] = mem_w_data_o;
    @(negedge clk);
    mem_w_ready_i = 1'b0;
    repeat (random_below(4)) @(negedge clk);
    mem_b_valid_i = 1'b1;
    while (!mem_b_ready_o) @(negedge clk);
    @(negedge clk);
    mem_b_valid_i = 1'b0;
  endtask

  always @(negedge clk) begin
    if (mem_aw_valid_o === 1'b1) begin
      serve_mem_write();
    end else if (mem_ar_valid_o === 1'b1) begin
      serve_mem_read();
    end
  end

  // latency counts negedges from the acceptance cycle to r_valid_o
  task automatic cpu_read(input int slot, input bit hold_ready, output word_t data,
                          output int latency);
    ar_addr_i  = slot_addr(slot);
    ar_valid_i = 1'b1;
    while (!ar_ready_o) @(negedge clk);
    @(negedge clk);
    ar_valid_i = 1'b0;
    latency    = 1;
    while (!r_valid_o) begin
      check_requests_blocked();
      @(negedge clk);
      latency++;
    end
    data      = r_data_o;
    r_ready_i = hold_ready || (random_below(2) == 1);
    while (!r_ready_i) begin
      check_requests_blocked();
      @(negedge clk);
      check_equal("r_valid_o", 1, r_valid_o);
      check_equal("r_data_o", data, r_data_o);  // held under back-pressure
      r_ready_i = (random_below(2) == 1);
    end
    check_requests_blocked();
    @(negedge clk);
    r_ready_i = 1'b0;
    check_equal("r_valid_o", 0, r_valid_o);
    check_equal("ar_ready_o", 1, ar_ready_o);
  endtask

  task automatic cpu_write(input int slot, input word_t data, input strb_t strb,
                           input bit hold_ready);
    aw_addr_i  = slot_addr(slot);
    aw_valid_i = 1'b1;
    while (!aw_ready_o) @(negedge clk);
    @(negedge clk);
    aw_valid_i = 1'b0;
    w_data_i   = data;
    w_strb_i   = strb;
    w_valid_i  = 1'b1;
    while (!w_ready_o) begin
      check_requests_blocked();
      @(negedge clk);
    end
    @(negedge clk);
    w_valid_i = 1'b0;
    check_equal("b_valid_o", 1, b_valid_o);  // one cycle after the w beat
    b_ready_i = hold_ready || (random_below(2) == 1);
    while (!b_ready_i) begin
      check_requests_blocked();
      @(negedge clk);
      check_equal("b_valid_o", 1, b_valid_o);
      b_ready_i = (random_below(2) == 1);
    end
    check_requests_blocked();
    @(negedge clk);
    b_ready_i = 1'b0;
    check_equal("aw_ready_o", 1, aw_ready_o);
    ref_mem[slot] = merge_bytes(ref_mem[slot], data, strb);
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    report_error("timeout, the cache stopped answering before all operations finished");
  end

  initial begin
    wait (i_dcache_top.i_dcache_assert.assert_errors != 0);
    report_error("a bound assertion failed, see the error above");
  end

  initial begin
    int    slot;
    int    last_slot;
    int    kind;
    int    latency;
    bit    hit_check;
    word_t data;
    rst            = 1'b1;
    ar_valid_i     = 1'b0;
    ar_addr_i      = '0;
    r_ready_i      = 1'b0;
    aw_valid_i     = 1'b0;
    aw_addr_i      = '0;
    w_valid_i      = 1'b0;
    w_data_i       = '0;
    w_strb_i       = '0;
    b_ready_i      = 1'b0;
    mem_ar_ready_i = 1'b0;
    mem_r_valid_i  = 1'b0;
    mem_r_data_i   = '0;
    mem_aw_ready_i = 1'b0;
    mem_w_ready_i  = 1'b0;
    mem_b_valid_i  = 1'b0;
    for (int i = 0; i < NUM_SLOTS; i++) begin
      mem_model[i] = {slot_addr(i), ~slot_addr(i)};
      ref_mem[i]   = mem_model[i];
    end
    repeat (3) begin
      @(negedge clk);
      check_reset_outputs();
    end
    rst = 1'b0;
    @(negedge clk);
    check_reset_outputs();
    last_slot = 0;
    for (int op = 0; op < NUM_OPS; op++) begin
      kind      = random_below(8);
      hit_check = (kind < 2) && (op > 0);  // repeat of the last address
      slot      = hit_check ? last_slot : random_below(NUM_SLOTS);
      if (kind < 5) begin
        cpu_read(slot, hit_check || (random_below(2) == 1), data, latency);
        check_equal("r_data_o", ref_mem[slot], data);
        if (hit_check) begin
          check_equal("read hit latency", 2, latency);
        end
      end else begin
        data[31:0]  = $random(seed);
        data[63:32] = $random(seed);
        cpu_write(slot, data, strb_t'(random_below(256)), random_below(2) == 1);
      end
      last_slot = slot;
    end
    // cache and memory together must hold the reference contents
    for (int i = 0; i < NUM_SLOTS; i++) begin
      cpu_read(i, 1'b0, data, latency);
      check_equal("r_data_o", ref_mem[i], data);
    end
    $display("Verification passed");
    $finish;
  end

endmodule

/* verification/dcache_assert.sv */
/*
  handshake and state checks, bound into every dcache_top
  assert_errors counts the failed checks
*/
`timescale 1ns/1ns

module dcache_assert (
  input logic                              clk,
  input logic                              rst,
  input logic                              ar_ready_o,
  input logic                              aw_ready_o,
  input logic                              r_valid_o,
  input logic                              r_ready_i,
  input logic [dcache_pkg::DATA_WIDTH-1:0] r_data_o,
  input logic                              b_valid_o,
  input logic                              b_ready_i,
  input logic                              mem_ar_valid_o,
  input logic                              mem_ar_ready_i,
  input logic [dcache_pkg::ADDR_WIDTH-1:0] mem_ar_addr_o,
  input logic                              mem_aw_valid_o,
  input logic                              mem_aw_ready_i,
  input logic [dcache_pkg::ADDR_WIDTH-1:0] mem_aw_addr_o,
  input logic                              mem_w_valid_o,
  input logic [dcache_pkg::STRB_WIDTH-1:0] mem_w_strb_o,
  input dcache_pkg::ctrl_state_e           state_i
);

  int assert_errors = 0;

  r_hold: assert property (@(posedge clk) disable iff (rst)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_data_o))
    else begin
      assert_errors++;
      $error("r_valid_o or r_data_o changed before r_ready_i");
    end

  b_hold: assert property (@(posedge clk) disable iff (rst)
    b_valid_o && !b_ready_i |=> b_valid_o)
    else begin
      assert_errors++;
      $error("b_valid_o dropped before b_ready_i");
    end

  mem_ar_hold: assert property (@(posedge clk) disable iff (rst)
    mem_ar_valid_o && !mem_ar_ready_i |=> mem_ar_valid_o && $stable(mem_ar_addr_o))
    else begin
      assert_errors++;
      $error("mem_ar_valid_o or address changed before ready");
    end

  mem_aw_hold: assert property (@(posedge clk) disable iff (rst)
    mem_aw_valid_o && !mem_aw_ready_i |=> mem_aw_valid_o && $stable(mem_aw_addr_o))
    else begin
      assert_errors++;
      $error("mem_aw_valid_o or address changed before ready");
    end

  // one request in service
  no_accept_pending: assert property (@(posedge clk) disable iff (rst)
    (r_valid_o || b_valid_o) |-> !ar_ready_o && !aw_ready_o)
    else begin
      assert_errors++;
      $error("request accepted while a response is pending");
    end

  full_line_wb: assert property (@(posedge clk) disable iff (rst)
    mem_w_valid_o |-> mem_w_strb_o == '1)
    else begin
      assert_errors++;
      $error("writeback without all strobes set");
    end

  legal_state: assert property (@(posedge clk) disable iff (rst)
    state_i <= dcache_pkg::MEM_R)
    else begin
      assert_errors++;
      $error("controller in an undefined state");
    end

endmodule

bind dcache_top dcache_assert i_dcache_assert (
  .*,
  .state_i (i_dcache_ctrl.state_q)
);

/* hdl/dcache_top.sv */
/*
  two-way write-back data cache, one 64-bit word per line
  plain cpu and memory ports, one beat per transfer
  no uncached access, no bursts, no error responses
*/
`timescale 1ns/1ns

module dcache_top #(
  parameter int INDEX_WIDTH = 6
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              ar_valid_i,
  output logic                              ar_ready_o,
  input  logic [dcache_pkg::ADDR_WIDTH-1:0] ar_addr_i,
  output logic                              r_valid_o,
  input  logic                              r_ready_i,
  output logic [dcache_pkg::DATA_WIDTH-1:0] r_data_o,
  input  logic                              aw_valid_i,
  output logic                              aw_ready_o,
  input  logic [dcache_pkg::ADDR_WIDTH-1:0] aw_addr_i,
  input  logic                              w_valid_i,
  output logic                              w_ready_o,
  input  logic [dcache_pkg::DATA_WIDTH-1:0] w_data_i,
  input  logic [dcache_pkg::STRB_WIDTH-1:0] w_strb_i,
  output logic                              b_valid_o,
  input  logic                              b_ready_i,
  output logic                              mem_ar_valid_o,
  input  logic                              mem_ar_ready_i,
  output logic [dcache_pkg::ADDR_WIDTH-1:0] mem_ar_addr_o,
  input  logic                              mem_r_valid_i,
  output logic                              mem_r_ready_o,
  input  logic [dcache_pkg::DATA_WIDTH-1:0] mem_r_data_i,
  output logic                              mem_aw_valid_o,
  input  logic                              mem_aw_ready_i,
  output logic [dcache_pkg::ADDR_WIDTH-1:0] mem_aw_addr_o,
  output logic                              mem_w_valid_o,
  input  logic                              mem_w_ready_i,
  output logic [dcache_pkg::DATA_WIDTH-1:0] mem_w_data_o,
  output logic [dcache_pkg::STRB_WIDTH-1:0] mem_w_strb_o,
  input  logic                              mem_b_valid_i,
  output logic                              mem_b_ready_o
);

  dcache_tag_if #(.INDEX_WIDTH(INDEX_WIDTH)) tag_if ();
  dcache_ram_if #(.INDEX_WIDTH(INDEX_WIDTH)) ram0_if ();  // way 0
  dcache_ram_if #(.INDEX_WIDTH(INDEX_WIDTH)) ram1_if ();  // way 1

  dcache_ctrl #(.INDEX_WIDTH(INDEX_WIDTH)) i_dcache_ctrl (
    .clk, .rst,
    .ar_valid_i, .ar_ready_o, .ar_addr_i, .r_valid_o, .r_ready_i, .r_data_o,
    .aw_valid_i, .aw_ready_o, .aw_addr_i, .w_valid_i, .w_ready_o, .w_data_i,
    .w_strb_i, .b_valid_o, .b_ready_i,
    .mem_ar_valid_o, .mem_ar_ready_i, .mem_ar_addr_o,
    .mem_r_valid_i, .mem_r_ready_o, .mem_r_data_i,
    .mem_aw_valid_o, .mem_aw_ready_i, .mem_aw_addr_o,
    .mem_w_valid_o, .mem_w_ready_i, .mem_w_data_o, .mem_w_strb_o,
    .mem_b_valid_i, .mem_b_ready_o,
    .tag  (tag_if),
    .ram0 (ram0_if),
    .ram1 (ram1_if)
  );

  dcache_tag_array #(.INDEX_WIDTH(INDEX_WIDTH)) i_dcache_tag_array (
    .clk, .rst,
    .tag (tag_if)
  );

  dcache_data_ram #(.INDEX_WIDTH(INDEX_WIDTH)) i_dcache_data_ram0 (.clk, .ram(ram0_if));
  dcache_data_ram #(.INDEX_WIDTH(INDEX_WIDTH)) i_dcache_data_ram1 (.clk, .ram(ram1_if));

endmodule

/* hdl/dcache_ctrl.sv */
/*
  blocking cache controller, one request in service at a time
  read beats write when both arrive together
  hit: r_valid_o or w_ready_o two cycles after the address transfer
  miss: writeback of a dirty victim, then refill, then served as a hit
  memory responses assumed OKAY, full-line writes only
*/
`timescale 1ns/1ns

module dcache_ctrl #(
  parameter int INDEX_WIDTH = 6
) (
  input  logic                              clk,
  input  logic                              rst,
  // cpu read
  input  logic                              ar_valid_i,
  output logic                              ar_ready_o,
  input  logic [dcache_pkg::ADDR_WIDTH-1:0] ar_addr_i,
  output logic                              r_valid_o,
  input  logic                              r_ready_i,
  output logic [dcache_pkg::DATA_WIDTH-1:0] r_data_o,
  // cpu write
  input  logic                              aw_valid_i,
  output logic                              aw_ready_o,
  input  logic [dcache_pkg::ADDR_WIDTH-1:0] aw_addr_i,
  input  logic                              w_valid_i,
  output logic                              w_ready_o,
  input  logic [dcache_pkg::DATA_WIDTH-1:0] w_data_i,
  input  logic [dcache_pkg::STRB_WIDTH-1:0] w_strb_i,
  output logic                              b_valid_o,
  input  logic                              b_ready_i,
  // memory
  output logic                              mem_ar_valid_o,
  input  logic                              mem_ar_ready_i,
  output logic [dcache_pkg::ADDR_WIDTH-1:0] mem_ar_addr_o,
  input  logic                              mem_r_valid_i,
  output logic                              mem_r_ready_o,
  input  logic [dcache_pkg::DATA_WIDTH-1:0] mem_r_data_i,
  output logic                              mem_aw_valid_o,
  input  logic                              mem_aw_ready_i,
  output logic [dcache_pkg::ADDR_WIDTH-1:0] mem_aw_addr_o,
  output logic                              mem_w_valid_o,
  input  logic                              mem_w_ready_i,
  output logic [dcache_pkg::DATA_WIDTH-1:0] mem_w_data_o,
  output logic [dcache_pkg::STRB_WIDTH-1:0] mem_w_strb_o,
  input  logic                              mem_b_valid_i,
  output logic                              mem_b_ready_o,
  dcache_tag_if.ctrl                        tag,
  dcache_ram_if.ctrl                        ram0,
  dcache_ram_if.ctrl                        ram1
);

  localparam int OFS     = dcache_pkg::OFFSET_WIDTH;
  localparam int TAG_LSB = INDEX_WIDTH + OFS;
  localparam int TAG_WIDTH = dcache_pkg::ADDR_WIDTH - TAG_LSB;

  dcache_pkg::ctrl_state_e state_q;

  logic                              is_write_q;
  logic                              way_q;
  logic [TAG_WIDTH-1:0]              tag_q;
  logic [INDEX_WIDTH-1:0]            index_q;
  logic [dcache_pkg::ADDR_WIDTH-1:0] req_addr;
  logic [INDEX_WIDTH-1:0]            ram_index;
  logic                              sel_way;
  logic [dcache_pkg::DATA_WIDTH-1:0] sel_rdata;
  logic ar_fire, aw_fire, accept, r_fire, w_fire, b_fire;
  logic mem_ar_fire, mem_r_fire, mem_aw_fire, mem_w_fire, mem_b_fire;
  logic fill;

  // accept only in IDLE, aw held off while ar is pending
  assign ar_ready_o = (state_q == dcache_pkg::IDLE);
  assign aw_ready_o = (state_q == dcache_pkg::IDLE) & ~ar_valid_i;

  assign ar_fire     = ar_valid_i & ar_ready_o;
  assign aw_fire     = aw_valid_i & aw_ready_o;
  assign accept      = ar_fire | aw_fire;
  assign r_fire      = r_valid_o & r_ready_i;
  assign w_fire      = w_valid_i & w_ready_o;
  assign b_fire      = b_valid_o & b_ready_i;
  assign mem_ar_fire = mem_ar_valid_o & mem_ar_ready_i;
  assign mem_r_fire  = mem_r_valid_i & mem_r_ready_o;
  assign mem_aw_fire = mem_aw_valid_o & mem_aw_ready_i;
  assign mem_w_fire  = mem_w_valid_o & mem_w_ready_i;
  assign mem_b_fire  = mem_b_valid_i & mem_b_ready_o;
  assign fill        = (state_q == dcache_pkg::MEM_R) & mem_r_fire;

  assign req_addr  = ar_valid_i ? ar_addr_i : aw_addr_i;
  assign ram_index = (state_q == dcache_pkg::IDLE) ? req_addr[TAG_LSB-1:OFS] : index_q;

  // hit way during lookup, latched way afterwards
  assign sel_way   = (state_q == dcache_pkg::LOOKUP) ? tag.hit_way : way_q;
  assign sel_rdata = sel_way ? ram1.rdata : ram0.rdata;

  assign mem_w_strb_o = {dcache_pkg::STRB_WIDTH{1'b1}};  // whole line

  // tag lookup and update
  assign tag.index     = ram_index;
  assign tag.tag       = tag_q;
  assign tag.lookup_en = (state_q == dcache_pkg::LOOKUP);
  assign tag.upd_en    = fill | w_fire;
  assign tag.upd_way   = way_q;
  assign tag.upd_valid = 1'b1;
  assign tag.upd_dirty = w_fire;  // refill installs clean
  assign tag.upd_tag   = tag_q;

  // data rams, written on refill or cpu write
  assign ram0.addr  = ram_index;
  assign ram0.we    = (fill | w_fire) & ~way_q;
  assign ram0.bwen  = w_fire ? w_strb_i : {dcache_pkg::STRB_WIDTH{1'b1}};
  assign ram0.wdata = w_fire ? w_data_i : mem_r_data_i;
  assign ram1.addr  = ram_index;
  assign ram1.we    = (fill | w_fire) & way_q;
  assign ram1.bwen  = w_fire ? w_strb_i : {dcache_pkg::STRB_WIDTH{1'b1}};
  assign ram1.wdata = w_fire ? w_data_i : mem_r_data_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q        <= dcache_pkg::IDLE;
      is_write_q     <= 1'b0;
      way_q          <= 1'b0;
      r_valid_o      <= 1'b0;
      w_ready_o      <= 1'b0;
      b_valid_o      <= 1'b0;
      mem_ar_valid_o <= 1'b0;
      mem_r_ready_o  <= 1'b0;
      mem_aw_valid_o <= 1'b0;
      mem_w_valid_o  <= 1'b0;
      mem_b_ready_o  <= 1'b0;
    end else begin
      case (state_q)
        dcache_pkg::IDLE: if (accept) begin
          is_write_q <= ~ar_fire;
          state_q    <= dcache_pkg::LOOKUP;
        end
        dcache_pkg::LOOKUP: begin
          if (tag.hit) begin
            way_q     <= tag.hit_way;
            r_valid_o <= ~is_write_q;
            w_ready_o <= is_write_q;
            state_q   <= dcache_pkg::HIT;
          end else begin
            way_q <= tag.victim_way;
            if (tag.victim_dirty) begin
              mem_aw_valid_o <= 1'b1;
              state_q        <= dcache_pkg::MEM_AW;
            end else begin
              mem_ar_valid_o <= 1'b1;
              state_q        <= dcache_pkg::MEM_AR;
            end
          end
        end
        dcache_pkg::HIT: begin
          if (w_fire) begin
            w_ready_o <= 1'b0;
            b_valid_o <= 1'b1;
          end
          if (r_fire | b_fire) begin
            r_valid_o <= 1'b0;
            b_valid_o <= 1'b0;
            state_q   <= dcache_pkg::IDLE;
          end
        end
        dcache_pkg::MEM_AW: if (mem_aw_fire) begin
          mem_aw_valid_o <= 1'b0;
          mem_w_valid_o  <= 1'b1;
          state_q        <= dcache_pkg::MEM_W;
        end
        dcache_pkg::MEM_W: if (mem_w_fire) begin
          mem_w_valid_o <= 1'b0;
          mem_b_ready_o <= 1'b1;
          state_q       <= dcache_pkg::MEM_B;
        end
        dcache_pkg::MEM_B: if (mem_b_fire) begin
          mem_b_ready_o  <= 1'b0;
          mem_ar_valid_o <= 1'b1;  // writeback done, now refill
          state_q        <= dcache_pkg::MEM_AR;
        end
        dcache_pkg::MEM_AR: if (mem_ar_fire) begin
          mem_ar_valid_o <= 1'b0;
          mem_r_ready_o  <= 1'b1;
          state_q        <= dcache_pkg::MEM_R;
        end
        dcache_pkg::MEM_R: if (mem_r_fire) begin
          mem_r_ready_o <= 1'b0;
          r_valid_o     <= ~is_write_q;
          w_ready_o     <= is_write_q;
          state_q       <= dcache_pkg::HIT;
        end
        default: state_q <= dcache_pkg::IDLE;
      endcase
    end
  end

  // address and data payloads
  always_ff @(posedge clk) begin
    if ((state_q == dcache_pkg::IDLE) && accept) begin
      tag_q   <= req_addr[dcache_pkg::ADDR_WIDTH-1:TAG_LSB];
      index_q <= req_addr[TAG_LSB-1:OFS];
    end
    if (state_q == dcache_pkg::LOOKUP) begin
      r_data_o      <= sel_rdata;
      mem_aw_addr_o <= {tag.victim_tag, index_q, {OFS{1'b0}}};
      mem_ar_addr_o <= {tag_q, index_q, {OFS{1'b0}}};
    end
    if ((state_q == dcache_pkg::MEM_AW) && mem_aw_fire) begin
      mem_w_data_o <= sel_rdata;  // victim word, ram still reads index_q
    end
    if (fill) begin
      r_data_o <= mem_r_data_i;
    end
  end

endmodule

/* hdl/dcache_data_ram.sv */
/*
  one way of data storage, one word per set
  behaves like a single-port macro: write or read, never both
  rdata holds its value during a write cycle
*/
`timescale 1ns/1ns

module dcache_data_ram #(
  parameter int INDEX_WIDTH = 6
) (
  input logic       clk,
  dcache_ram_if.ram ram
);

  localparam int SETS = 2 ** INDEX_WIDTH;

  logic [dcache_pkg::DATA_WIDTH-1:0] mem [SETS];

  always_ff @(posedge clk) begin
    if (ram.we) begin
      // per-byte write
      for (int b = 0; b < dcache_pkg::STRB_WIDTH; b++) begin
        if (ram.bwen[b]) begin
          mem[ram.addr][8*b +: 8] <= ram.wdata[8*b +: 8];
        end
      end
    end else begin
      ram.rdata <= mem[ram.addr];
    end
  end

endmodule

/* hdl/dcache_tag_array.sv */
/*
  tag, valid and dirty bits for both ways of every set
  valid and dirty clear on reset, tags do not
  victim is a free-running one-bit counter, frozen while lookup_en is low
  victim_dirty already includes the valid bit
*/
`timescale 1ns/1ns

module dcache_tag_array #(
  parameter int INDEX_WIDTH = 6
) (
  input logic          clk,
  input logic          rst,
  dcache_tag_if.array  tag
);

  localparam int TAG_WIDTH = dcache_pkg::ADDR_WIDTH - INDEX_WIDTH - dcache_pkg::OFFSET_WIDTH;
  localparam int SETS      = 2 ** INDEX_WIDTH;

  logic [TAG_WIDTH-1:0] tag_mem [dcache_pkg::NUM_WAYS][SETS];
  logic [dcache_pkg::NUM_WAYS-1:0][SETS-1:0] valid_q;
  logic [dcache_pkg::NUM_WAYS-1:0][SETS-1:0] dirty_q;
  logic [dcache_pkg::NUM_WAYS-1:0] way_hit;
  logic cnt_q;     // replacement counter
  logic victim_q;  // last sampled victim

  // compare both ways
  always_comb begin
    for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
      way_hit[w] = valid_q[w][tag.index] && (tag_mem[w][tag.index] == tag.tag);
    end
  end

  assign tag.hit     = |way_hit;
  assign tag.hit_way = way_hit[1];

  // victim sampled from the counter during lookup, held afterwards
  assign tag.victim_way   = tag.lookup_en ? cnt_q : victim_q;
  assign tag.victim_dirty = valid_q[tag.victim_way][tag.index] &
                            dirty_q[tag.victim_way][tag.index];
  assign tag.victim_tag   = tag_mem[tag.victim_way][tag.index];

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt_q    <= 1'b0;
      victim_q <= 1'b0;
      valid_q  <= '0;
      dirty_q  <= '0;
    end else begin
      cnt_q <= ~cnt_q;  // advances every cycle
      if (tag.lookup_en) begin
        victim_q <= cnt_q;
      end
      if (tag.upd_en) begin
        valid_q[tag.upd_way][tag.index] <= tag.upd_valid;
        dirty_q[tag.upd_way][tag.index] <= tag.upd_dirty;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (tag.upd_en) begin
      tag_mem[tag.upd_way][tag.index] <= tag.upd_tag;
    end
  end

endmodule

/* hdl/dcache_if.sv */
/*
  internal cache buses between controller, tag array and data rams
  ram rdata is valid one cycle after addr with we low
  tag lookup results are combinational from index and tag
*/
`timescale 1ns/1ns

// data ram port, one instance per way
interface dcache_ram_if #(
  parameter int INDEX_WIDTH = 6
);
  logic [INDEX_WIDTH-1:0]            addr;
  logic                              we;
  logic [dcache_pkg::STRB_WIDTH-1:0] bwen;  // byte mask, 1 = write
  logic [dcache_pkg::DATA_WIDTH-1:0] wdata;
  logic [dcache_pkg::DATA_WIDTH-1:0] rdata;

  modport ctrl (output addr, we, bwen, wdata, input rdata);
  modport ram  (input addr, we, bwen, wdata, output rdata);
endinterface

// tag lookup and update
interface dcache_tag_if #(
  parameter int INDEX_WIDTH = 6
);
  localparam int TAG_WIDTH = dcache_pkg::ADDR_WIDTH - INDEX_WIDTH - dcache_pkg::OFFSET_WIDTH;

  logic [INDEX_WIDTH-1:0] index;  // shared by lookup and update
  logic [TAG_WIDTH-1:0]   tag;
  logic                   lookup_en;
  logic                   hit;
  logic                   hit_way;
  logic                   victim_way;
  logic                   victim_dirty;
  logic [TAG_WIDTH-1:0]   victim_tag;
  logic                   upd_en;
  logic                   upd_way;
  logic                   upd_valid;
  logic                   upd_dirty;
  logic [TAG_WIDTH-1:0]   upd_tag;

  modport ctrl (
    output index, tag, lookup_en, upd_en, upd_way, upd_valid, upd_dirty, upd_tag,
    input  hit, hit_way, victim_way, victim_dirty, victim_tag
  );
  modport array (
    input  index, tag, lookup_en, upd_en, upd_way, upd_valid, upd_dirty, upd_tag,
    output hit, hit_way, victim_way, victim_dirty, victim_tag
  );
endinterface

/* hdl/dcache_pkg.sv */
/*
  shared widths, address split and controller states for the data cache
  address = | tag | index | offset |, one 64-bit word per line
  two ways only, victim choice and hit encoding depend on it
  index width is a module parameter, not defined here
*/
package dcache_pkg;

  localparam int ADDR_WIDTH   = 32;
  localparam int DATA_WIDTH   = 64; // word and line
  localparam int STRB_WIDTH   = DATA_WIDTH / 8;
  localparam int OFFSET_WIDTH = 3;  // byte within the line

  // fixed, see header
  localparam int NUM_WAYS = 2;

  // controller FSM
  typedef enum logic [3:0] {
    IDLE   = 4'd0, // waiting for ar or aw
    LOOKUP = 4'd1, // tag compare and ram read
    HIT    = 4'd2, // serving r, or w then b
    MEM_AW = 4'd3,
    MEM_W  = 4'd4,
    MEM_B  = 4'd5,
    MEM_AR = 4'd6,
    MEM_R  = 4'd7
  } ctrl_state_e;

endpackage
